// ==== glb_consts.svh ====
//####################################################################
// global buffer constants
// bank geometry and configuration bus widths shared by all blocks,
// plus the field layout of the configuration address
//####################################################################

`ifndef GLB_INCLUDED_CONSTS
`define GLB_INCLUDED_CONSTS

// bank geometry
`define GLB_NUM_BANKS           4
`define GLB_BANK_DATA_WIDTH     64
`define GLB_BANK_ADDR_WIDTH     8

// configuration bus
`define GLB_CFG_ADDR_WIDTH      32
`define GLB_CFG_DATA_WIDTH      32

// configuration address fields: half select, word address, bank
`define GLB_CFG_HALF_BIT        0
`define GLB_CFG_WORD_LSB        1
`define GLB_CFG_BANK_LSB        (`GLB_CFG_WORD_LSB + `GLB_BANK_ADDR_WIDTH)
`define GLB_BANK_SEL_WIDTH      $clog2(`GLB_NUM_BANKS)

// words per bank
`define GLB_BANK_DEPTH          (1 << `GLB_BANK_ADDR_WIDTH)

`endif

// ==== glb_port_pkg.sv ====
//####################################################################
// global buffer port types
// request structs for the host and CGRA sides of a bank
//####################################################################

`default_nettype none

`include "glb_consts.svh"

package glb_port_pkg;

    // write strobe with word address and full bank word (73 bits)
    typedef struct packed {
        logic                             en;
        logic [`GLB_BANK_ADDR_WIDTH-1:0]  addr;
        logic [`GLB_BANK_DATA_WIDTH-1:0]  data;
    } wr_req_t;

    // read strobe with word address (9 bits)
    typedef struct packed {
        logic                             en;
        logic [`GLB_BANK_ADDR_WIDTH-1:0]  addr;
    } rd_req_t;

    // half-word write enables, bit 0 low half, bit 1 high half
    typedef logic [1:0] word_mask_t;

endpackage

`default_nettype wire

// ==== glb_cfg_pkg.sv ====
//####################################################################
// global buffer configuration types
// the 32-bit configuration request and the per-bank opcode
//####################################################################

`default_nettype none

`include "glb_consts.svh"

package glb_cfg_pkg;

    // configuration bus request (67 bits)
    typedef struct packed {
        logic                             en;       // access to the buffer
        logic                             wr;
        logic                             rd;
        logic [`GLB_CFG_ADDR_WIDTH-1:0]   addr;     // bank / word / half
        logic [`GLB_CFG_DATA_WIDTH-1:0]   wr_data;
    } cfg_req_t;

    // what a bank does with the configuration request this cycle
    typedef enum logic [1:0] {
        CFG_IDLE  = 2'd0,
        CFG_WRITE = 2'd1,
        CFG_READ  = 2'd2
    } cfg_op_e;

endpackage

`default_nettype wire

// ==== glb_bank_sram.sv ====
//####################################################################
// bank word array
// 256 x 64 array with two sides, each with one write and one
// registered read per cycle; side A writes are half-word masked
//####################################################################

`default_nettype none

`include "glb_consts.svh"

module glb_bank_sram (
    input  logic                             clk,
    input  logic                             arst_n,
    input  glb_port_pkg::wr_req_t            a_wr,
    input  glb_port_pkg::word_mask_t         a_mask,
    input  glb_port_pkg::rd_req_t            a_rd,
    input  glb_port_pkg::wr_req_t            b_wr,
    input  glb_port_pkg::rd_req_t            b_rd,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]  a_rd_data,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]  b_rd_data
);

    logic [`GLB_BANK_DATA_WIDTH-1:0] mem [0:`GLB_BANK_DEPTH-1];

    // side B first, side A last so A wins on the same address
    always_ff @(posedge clk) begin
        if (b_wr.en) begin
            mem[b_wr.addr] <= b_wr.data;
        end
        if (a_wr.en) begin
            if (a_mask[0]) begin
                mem[a_wr.addr][0 +: `GLB_CFG_DATA_WIDTH] <=
                    a_wr.data[0 +: `GLB_CFG_DATA_WIDTH];
            end
            if (a_mask[1]) begin
                mem[a_wr.addr][`GLB_CFG_DATA_WIDTH +: `GLB_CFG_DATA_WIDTH] <=
                    a_wr.data[`GLB_CFG_DATA_WIDTH +: `GLB_CFG_DATA_WIDTH];
            end
        end
    end

    // read data holds until the next read on that side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_rd_data <= '0;
            b_rd_data <= '0;
        end else begin
            if (a_rd.en) begin
                a_rd_data <= mem[a_rd.addr];  // old data on same-cycle write
            end
            if (b_rd.en) begin
                b_rd_data <= mem[b_rd.addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== glb_cfg_adapter.sv ====
//####################################################################
// configuration adapter
// maps a 32-bit configuration access onto a masked 64-bit word
// access and returns the addressed half one cycle after a read
//####################################################################

`default_nettype none

`include "glb_consts.svh"

module glb_cfg_adapter (
    input  logic                             clk,
    input  logic                             arst_n,
    input  glb_cfg_pkg::cfg_req_t            cfg,
    input  logic                             cfg_sel,
    output glb_port_pkg::wr_req_t            wr_req,
    output glb_port_pkg::word_mask_t         wr_mask,
    output glb_port_pkg::rd_req_t            rd_req,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]  rd_word,
    output logic [`GLB_CFG_DATA_WIDTH-1:0]   cfg_rd_data
);

    import glb_cfg_pkg::*;

    cfg_op_e                          op;
    logic                             half;
    logic [`GLB_BANK_ADDR_WIDTH-1:0]  word_addr;
    logic                             rd_pend;
    logic                             half_q;

    //################################################################
    // request side
    //################################################################

    always_comb begin
        if (!cfg_sel) begin
            op = CFG_IDLE;
        end else if (cfg.wr) begin
            op = CFG_WRITE;      // write takes precedence over read
        end else if (cfg.rd) begin
            op = CFG_READ;
        end else begin
            op = CFG_IDLE;
        end
    end

    assign half      = cfg.addr[`GLB_CFG_HALF_BIT];
    assign word_addr = cfg.addr[`GLB_CFG_WORD_LSB +: `GLB_BANK_ADDR_WIDTH];

    // data copied to both halves, the mask picks the one that lands
    assign wr_req.en   = (op == CFG_WRITE);
    assign wr_req.addr = word_addr;
    assign wr_req.data = {2{cfg.wr_data}};
    assign wr_mask     = half ? 2'b10 : 2'b01;

    assign rd_req.en   = (op == CFG_READ);
    assign rd_req.addr = word_addr;

    //################################################################
    // return side
    //################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_pend <= 1'b0;
            half_q  <= 1'b0;
        end else begin
            rd_pend <= (op == CFG_READ);
            half_q  <= half;
        end
    end

    // zero unless answering, so the top level can OR all banks
    assign cfg_rd_data = !rd_pend ? '0 :
                         half_q   ? rd_word[`GLB_CFG_DATA_WIDTH +: `GLB_CFG_DATA_WIDTH] :
                                    rd_word[0 +: `GLB_CFG_DATA_WIDTH];

endmodule

`default_nettype wire

// ==== memory_bank.sv ====
//####################################################################
// memory bank
// one global buffer bank; the configuration adapter shares the
// host side of the word array and takes it over when selected
//####################################################################

`default_nettype none

`include "glb_consts.svh"

module memory_bank (
    input  logic                             clk,
    input  logic                             arst_n,
    input  glb_port_pkg::wr_req_t            host_wr,
    input  glb_port_pkg::rd_req_t            host_rd,
    input  glb_port_pkg::wr_req_t            cgra_wr,
    input  glb_port_pkg::rd_req_t            cgra_rd,
    input  glb_cfg_pkg::cfg_req_t            cfg,
    input  logic                             cfg_sel,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]  host_rd_data,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]  cgra_rd_data,
    output logic [`GLB_CFG_DATA_WIDTH-1:0]   cfg_rd_data
);

    import glb_port_pkg::*;

    wr_req_t     cfg_wr_req;
    word_mask_t  cfg_wr_mask;
    rd_req_t     cfg_rd_req;
    wr_req_t     a_wr;
    word_mask_t  a_mask;
    rd_req_t     a_rd;

    glb_cfg_adapter u_cfg_adapter (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .cfg_sel     (cfg_sel),
        .wr_req      (cfg_wr_req),
        .wr_mask     (cfg_wr_mask),
        .rd_req      (cfg_rd_req),
        .rd_word     (host_rd_data),     // shares the host read register
        .cfg_rd_data (cfg_rd_data)
    );

    // configuration owns the host side for the whole cycle,
    // the host access of that cycle is dropped
    always_comb begin
        if (cfg_sel) begin
            a_wr   = cfg_wr_req;
            a_mask = cfg_wr_mask;
            a_rd   = cfg_rd_req;
        end else begin
            a_wr   = host_wr;
            a_mask = '1;                  // host writes whole words
            a_rd   = host_rd;
        end
    end

    glb_bank_sram u_sram (
        .clk       (clk),
        .arst_n    (arst_n),
        .a_wr      (a_wr),
        .a_mask    (a_mask),
        .a_rd      (a_rd),
        .b_wr      (cgra_wr),
        .b_rd      (cgra_rd),
        .a_rd_data (host_rd_data),
        .b_rd_data (cgra_rd_data)
    );

endmodule

`default_nettype wire

// ==== global_buffer.sv ====
//####################################################################
// global buffer
// banked buffer between host and CGRA fabric; each bank has its own
// host and CGRA ports, and a shared 32-bit configuration bus reaches
// one bank at a time through the bank field of its address
//####################################################################

`default_nettype none

`include "glb_consts.svh"

module global_buffer (
    input  logic                             clk,
    input  logic                             arst_n,

    // host side, one port pair per bank
    input  glb_port_pkg::wr_req_t            host_wr      [`GLB_NUM_BANKS-1:0],
    input  glb_port_pkg::rd_req_t            host_rd      [`GLB_NUM_BANKS-1:0],
    output logic [`GLB_BANK_DATA_WIDTH-1:0]  host_rd_data [`GLB_NUM_BANKS-1:0],

    // CGRA side, one port pair per bank
    input  glb_port_pkg::wr_req_t            cgra_wr      [`GLB_NUM_BANKS-1:0],
    input  glb_port_pkg::rd_req_t            cgra_rd      [`GLB_NUM_BANKS-1:0],
    output logic [`GLB_BANK_DATA_WIDTH-1:0]  cgra_rd_data [`GLB_NUM_BANKS-1:0],

    // configuration bus
    input  glb_cfg_pkg::cfg_req_t            cfg,
    output logic [`GLB_CFG_DATA_WIDTH-1:0]   cfg_rd_data
);

    logic [`GLB_BANK_SEL_WIDTH-1:0]  cfg_bank;
    logic [`GLB_NUM_BANKS-1:0]       cfg_sel;
    logic [`GLB_CFG_DATA_WIDTH-1:0]  cfg_rd_data_bank [`GLB_NUM_BANKS-1:0];

    //################################################################
    // configuration decode
    //################################################################

    // bits above the bank field are ignored
    assign cfg_bank = cfg.addr[`GLB_CFG_BANK_LSB +: `GLB_BANK_SEL_WIDTH];

    // idle banks return zero, so a plain OR gives the answer
    always_comb begin
        cfg_rd_data = '0;
        for (int j = 0; j < `GLB_NUM_BANKS; j++) begin
            cfg_rd_data = cfg_rd_data | cfg_rd_data_bank[j];
        end
    end

    //################################################################
    // banks
    //################################################################

    for (genvar i = 0; i < `GLB_NUM_BANKS; i++) begin : g_bank
        localparam logic [`GLB_BANK_SEL_WIDTH-1:0] BANK_ID = i;

        assign cfg_sel[i] = cfg.en && (cfg_bank == BANK_ID);   // one-hot

        memory_bank u_bank (
            .clk          (clk),
            .arst_n       (arst_n),
            .host_wr      (host_wr[i]),
            .host_rd      (host_rd[i]),
            .cgra_wr      (cgra_wr[i]),
            .cgra_rd      (cgra_rd[i]),
            .cfg          (cfg),
            .cfg_sel      (cfg_sel[i]),
            .host_rd_data (host_rd_data[i]),
            .cgra_rd_data (cgra_rd_data[i]),
            .cfg_rd_data  (cfg_rd_data_bank[i])
        );
    end : g_bank

endmodule

`default_nettype wire

// ==== glb_assert.sv ====
//####################################################################
// global buffer assertions
// protocol checks bound into the top level of the buffer
//####################################################################

`default_nettype none

`include "glb_consts.svh"

module glb_assert (
    input  logic                             clk,
    input  logic                             arst_n,
    input  glb_cfg_pkg::cfg_req_t            cfg,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0]   cfg_rd_data_bank [`GLB_NUM_BANKS-1:0],
    input  logic [`GLB_CFG_DATA_WIDTH-1:0]   cfg_rd_data,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]  host_rd_data [`GLB_NUM_BANKS-1:0],
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]  cgra_rd_data [`GLB_NUM_BANKS-1:0]
);

    int                         assert_errors = 0;
    logic [`GLB_NUM_BANKS-1:0]  cfg_answering;

    for (genvar i = 0; i < `GLB_NUM_BANKS; i++) begin : g_answer
        assign cfg_answering[i] = (cfg_rd_data_bank[i] != '0);   // bank drives read data
    end : g_answer

    // only a pure read returns data since a write wins over a read
    a_cfg_rd_idle_zero : assert property (@(posedge clk) disable iff (!arst_n)
        !$past(cfg.en && cfg.rd && !cfg.wr) |-> (cfg_rd_data == '0))
        else begin
            $error("configuration read data without a preceding read");
            assert_errors++;
        end

    a_cfg_one_bank : assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(cfg_answering))
        else begin
            $error("more than one bank answering the configuration bus");
            assert_errors++;
        end

    for (genvar i = 0; i < `GLB_NUM_BANKS; i++) begin : g_known
        a_rd_known : assert property (@(posedge clk) disable iff (!arst_n)
            !$isunknown(host_rd_data[i]) && !$isunknown(cgra_rd_data[i]))
            else begin
                $error("bank %0d read data unknown", i);
                assert_errors++;
            end
    end : g_known

endmodule

bind global_buffer glb_assert u_glb_assert (
    .clk              (clk),
    .arst_n           (arst_n),
    .cfg              (cfg),
    .cfg_rd_data_bank (cfg_rd_data_bank),
    .cfg_rd_data      (cfg_rd_data),
    .host_rd_data     (host_rd_data),
    .cgra_rd_data     (cgra_rd_data)
);

`default_nettype wire

// ==== glb_checker.sv ====
//####################################################################
// global buffer checker
// reference model of all banks; compares every read one cycle after
// its strobe and keeps the per-test and total error counts
//####################################################################

`default_nettype none

`include "glb_consts.svh"

module glb_checker (
    input  logic                             clk,
    input  logic                             arst_n,
    input  glb_port_pkg::wr_req_t            host_wr      [`GLB_NUM_BANKS-1:0],
    input  glb_port_pkg::rd_req_t            host_rd      [`GLB_NUM_BANKS-1:0],
    input  glb_port_pkg::wr_req_t            cgra_wr      [`GLB_NUM_BANKS-1:0],
    input  glb_port_pkg::rd_req_t            cgra_rd      [`GLB_NUM_BANKS-1:0],
    input  glb_cfg_pkg::cfg_req_t            cfg,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]  host_rd_data [`GLB_NUM_BANKS-1:0],
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]  cgra_rd_data [`GLB_NUM_BANKS-1:0],
    input  logic [`GLB_CFG_DATA_WIDTH-1:0]   cfg_rd_data,
    input  logic [`GLB_NUM_BANKS-1:0]        exp_host_en,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]  exp_host_val [`GLB_NUM_BANKS-1:0],
    input  logic [`GLB_NUM_BANKS-1:0]        exp_cgra_en,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]  exp_cgra_val [`GLB_NUM_BANKS-1:0],
    input  logic                             exp_cfg_en,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0]   exp_cfg_val,
    input  int                               test_id,
    input  logic                             test_end,
    output int                               tests_passed,
    output int                               tests_failed,
    output int                               error_count
);

    import glb_port_pkg::*;
    import glb_cfg_pkg::*;

    localparam int NB = `GLB_NUM_BANKS;

    logic [63:0]    model [NB][256];
    logic [63:0]    host_q [NB];
    logic [63:0]    cgra_q [NB];
    logic [63:0]    host_fexp [NB];
    logic [63:0]    cgra_fexp [NB];
    logic [NB-1:0]  host_chk, cgra_chk, host_fchk, cgra_fchk;
    logic [31:0]    cfg_q, cfg_fexp;
    logic           cfg_fchk;
    int             test_errors;

    initial begin
        tests_passed = 0;
        tests_failed = 0;
        error_count  = 0;
        test_errors  = 0;
    end

    task automatic report(input string msg);
        $display("MISMATCH at time %0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    //################################################################
    // model update at the clock edge
    //################################################################

    always @(posedge clk or negedge arst_n) begin : model_update
        logic [1:0]  cbank;
        logic [7:0]  cword;
        logic        chalf;
        logic        sel;
        if (!arst_n) begin
            for (int b = 0; b < NB; b++) begin
                host_q[b] <= '0;
                cgra_q[b] <= '0;
            end
            host_chk  <= '0;
            cgra_chk  <= '0;
            host_fchk <= '0;
            cgra_fchk <= '0;
            cfg_q     <= '0;
            cfg_fchk  <= 1'b0;
        end else begin
            cbank = cfg.addr[10:9];
            cword = cfg.addr[8:1];
            chalf = cfg.addr[0];
            cfg_q <= '0;                        // zero unless a read answers
            for (int b = 0; b < NB; b++) begin
                sel = cfg.en && (cbank == 2'(b));
                host_chk[b] <= 1'b0;
                // reads see the word before this edge's writes
                if (sel && cfg.rd && !cfg.wr) begin
                    host_q[b]   <= model[b][cword];
                    host_chk[b] <= 1'b1;
                    cfg_q       <= chalf ? model[b][cword][63:32] : model[b][cword][31:0];
                end else if (!sel && host_rd[b].en) begin
                    host_q[b]   <= model[b][host_rd[b].addr];
                    host_chk[b] <= 1'b1;
                end
                cgra_chk[b] <= cgra_rd[b].en;
                if (cgra_rd[b].en) begin
                    cgra_q[b] <= model[b][cgra_rd[b].addr];
                end
                // cgra first, host or config last so it wins
                if (cgra_wr[b].en) begin
                    model[b][cgra_wr[b].addr] = cgra_wr[b].data;
                end
                if (sel && cfg.wr) begin
                    if (chalf) begin
                        model[b][cword][63:32] = cfg.wr_data;
                    end else begin
                        model[b][cword][31:0] = cfg.wr_data;
                    end
                end else if (!sel && host_wr[b].en) begin
                    model[b][host_wr[b].addr] = host_wr[b].data;   // dropped if sel
                end
                host_fchk[b] <= exp_host_en[b];
                host_fexp[b] <= exp_host_val[b];
                cgra_fchk[b] <= exp_cgra_en[b];
                cgra_fexp[b] <= exp_cgra_val[b];
            end
            cfg_fchk <= exp_cfg_en;
            cfg_fexp <= exp_cfg_val;
        end
    end

    //################################################################
    // compare mid-cycle where the read data is stable
    //################################################################

    always @(negedge clk) begin
        if (arst_n) begin
            for (int b = 0; b < NB; b++) begin
                if (host_chk[b] && host_rd_data[b] !== host_q[b])
                    report($sformatf("bank %0d host read %h, model %h",
                                     b, host_rd_data[b], host_q[b]));
                if (host_fchk[b] && host_rd_data[b] !== host_fexp[b])
                    report($sformatf("bank %0d host read %h, file expects %h",
                                     b, host_rd_data[b], host_fexp[b]));
                if (cgra_chk[b] && cgra_rd_data[b] !== cgra_q[b])
                    report($sformatf("bank %0d cgra read %h, model %h",
                                     b, cgra_rd_data[b], cgra_q[b]));
                if (cgra_fchk[b] && cgra_rd_data[b] !== cgra_fexp[b])
                    report($sformatf("bank %0d cgra read %h, file expects %h",
                                     b, cgra_rd_data[b], cgra_fexp[b]));
            end
            if (cfg_rd_data !== cfg_q)
                report($sformatf("cfg read %h, model %h", cfg_rd_data, cfg_q));
            if (cfg_fchk && cfg_rd_data !== cfg_fexp)
                report($sformatf("cfg read %h, file expects %h", cfg_rd_data, cfg_fexp));
        end
    end

    always @(posedge clk) begin
        if (arst_n && test_end) begin
            if (test_errors == 0) begin
                $display("test %0d done: ok", test_id);
                tests_passed++;
            end else begin
                $display("test %0d done: %0d errors", test_id, test_errors);
                tests_failed++;
            end
            test_errors = 0;
        end
    end

endmodule

`default_nettype wire

// ==== glb_tb.sv ====
//####################################################################
// global buffer testbench
// file-driven directed tests followed by LFSR traffic on all sides
//####################################################################

`default_nettype none

`include "glb_consts.svh"

module glb_tb;

    import glb_port_pkg::*;
    import glb_cfg_pkg::*;

    localparam int NB          = `GLB_NUM_BANKS;
    localparam int MAX_LINES   = 1000;
    localparam int RAND_CYCLES = 200;

    logic         clk;
    logic         arst_n;
    wr_req_t      host_wr [NB-1:0];
    rd_req_t      host_rd [NB-1:0];
    wr_req_t      cgra_wr [NB-1:0];
    rd_req_t      cgra_rd [NB-1:0];
    cfg_req_t     cfg;
    logic [63:0]  host_rd_data [NB-1:0];
    logic [63:0]  cgra_rd_data [NB-1:0];
    logic [31:0]  cfg_rd_data;
    logic [NB-1:0] exp_host_en, exp_cgra_en;
    logic [63:0]  exp_host_val [NB-1:0];
    logic [63:0]  exp_cgra_val [NB-1:0];
    logic         exp_cfg_en;
    logic [31:0]  exp_cfg_val;
    logic         test_end;
    int           test_id, tests_passed, tests_failed, error_count, input_errors;
    logic [31:0]  lfsr;
    bit           hung;

    global_buffer dut0 (
        .clk (clk), .arst_n (arst_n),
        .host_wr (host_wr), .host_rd (host_rd), .host_rd_data (host_rd_data),
        .cgra_wr (cgra_wr), .cgra_rd (cgra_rd), .cgra_rd_data (cgra_rd_data),
        .cfg (cfg), .cfg_rd_data (cfg_rd_data)
    );

    glb_checker u_checker (
        .clk (clk), .arst_n (arst_n),
        .host_wr (host_wr), .host_rd (host_rd), .cgra_wr (cgra_wr), .cgra_rd (cgra_rd),
        .cfg (cfg), .host_rd_data (host_rd_data), .cgra_rd_data (cgra_rd_data),
        .cfg_rd_data (cfg_rd_data),
        .exp_host_en (exp_host_en), .exp_host_val (exp_host_val),
        .exp_cgra_en (exp_cgra_en), .exp_cgra_val (exp_cgra_val),
        .exp_cfg_en (exp_cfg_en), .exp_cfg_val (exp_cfg_val),
        .test_id (test_id), .test_end (test_end),
        .tests_passed (tests_passed), .tests_failed (tests_failed),
        .error_count (error_count)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2 arst_n = 1'b1;
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic clear_inputs();
        for (int b = 0; b < NB; b++) begin
            host_wr[b] = '0;
            host_rd[b] = '0;
            cgra_wr[b] = '0;
            cgra_rd[b] = '0;
            exp_host_val[b] = '0;
            exp_cgra_val[b] = '0;
        end
        cfg         = '0;
        exp_host_en = '0;
        exp_cgra_en = '0;
        exp_cfg_en  = 1'b0;
        exp_cfg_val = '0;
        test_end    = 1'b0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
        clear_inputs();
    endtask

    // two idle cycles let the last read be compared first
    task automatic end_test();
        next_cycle();
        next_cycle();
        test_end = 1'b1;
        next_cycle();
    endtask

    task automatic apply_access(input logic [63:0] side, input logic [63:0] op, input int bank,
                                input logic [63:0] addr, input logic [63:0] data,
                                input logic [63:0] expv);
        if (side == "host" && op == "wr") begin
            host_wr[bank] = '{en: 1'b1, addr: addr[7:0], data: data};
        end else if (side == "host" && op == "rd") begin
            host_rd[bank]     = '{en: 1'b1, addr: addr[7:0]};
            exp_host_en[bank] = 1'b1;
            exp_host_val[bank] = expv;
        end else if (side == "cgra" && op == "wr") begin
            cgra_wr[bank] = '{en: 1'b1, addr: addr[7:0], data: data};
        end else if (side == "cgra" && op == "rd") begin
            cgra_rd[bank]     = '{en: 1'b1, addr: addr[7:0]};
            exp_cgra_en[bank] = 1'b1;
            exp_cgra_val[bank] = expv;
        end else if (side == "cfg" && (op == "wr" || op == "rd")) begin
            cfg.en      = 1'b1;
            cfg.wr      = (op == "wr");
            cfg.rd      = (op == "rd");
            cfg.addr    = (32'(bank) << 9) | 32'(addr[8:0]);   // bank, word, half
            cfg.wr_data = data[31:0];
            exp_cfg_en  = (op == "rd");
            exp_cfg_val = expv[31:0];
        end else if (!(side == "cfg" && op == "nop")) begin
            $display("input file holds an unknown access %0s %0s", side, op);
            input_errors++;
        end
    endtask

    task automatic random_traffic();
        logic [63:0] v, a, d, w, h;
        test_id = 6;
        for (int i = 0; i < 16; i++) begin
            for (int b = 0; b < NB; b++) begin
                host_wr[b] = '{en: 1'b1, addr: 8'(i), data: {2{8'(b), 8'(i), 16'h5aa5}}};
            end
            next_cycle();
        end
        for (int c = 0; c < RAND_CYCLES; c++) begin
            for (int b = 0; b < NB; b++) begin
                take_bits(2, v);
                take_bits(4, a);
                take_bits(64, d);
                if (v[1:0] == 2'd1) host_wr[b] = '{en: 1'b1, addr: a[7:0], data: d};
                if (v[1]) host_rd[b] = '{en: 1'b1, addr: a[7:0]};
                take_bits(2, v);
                take_bits(4, a);
                take_bits(64, d);
                if (v[1:0] == 2'd1) cgra_wr[b] = '{en: 1'b1, addr: a[7:0], data: d};
                if (v[1]) cgra_rd[b] = '{en: 1'b1, addr: a[7:0]};
            end
            take_bits(2, v);
            take_bits(2, a);
            take_bits(4, w);
            take_bits(1, h);
            take_bits(32, d);
            if (v[1]) apply_access("cfg", v[0] ? "rd" : "wr", int'(a[1:0]),
                                   {w[7:0], h[0]}, d, 64'h0);
            exp_cfg_en = 1'b0;                  // checked against the model only
            next_cycle();
        end
        end_test();
    endtask

    initial begin : main
        int fd, n, lines, t, jn, bank, cur_test, cyc;
        logic [63:0] side, op, addr, data, expv;
        logic [8*256-1:0] line;
        hung         = 1'b0;
        input_errors = 0;
        test_id      = 0;
        lfsr         = 32'hcd59_e43e;
        clear_inputs();
        cyc = 0;
        while (arst_n !== 1'b1 && cyc < 20) begin
            @(posedge clk);
            cyc++;
        end
        if (arst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            hung = 1'b1;
        end else begin
            next_cycle();
            fd = $fopen("glb_input.txt", "r");
            if (fd == 0) begin
                $display("cannot open the stimulus file glb_input.txt");
                hung = 1'b1;
            end else begin
                cur_test = -1;
                lines    = 0;
                while (!$feof(fd) && lines < MAX_LINES) begin
                    lines++;
                    if ($fgets(line, fd) != 0) begin
                        n = $sscanf(line, "%d %d %s %s %d %h %h %h",
                                    t, jn, side, op, bank, addr, data, expv);
                        if (n == 8) begin               // comment lines fail to parse
                            if (t != cur_test) begin
                                if (cur_test >= 0) end_test();
                                cur_test = t;
                                test_id  = t;
                            end
                            apply_access(side, op, bank, addr, data, expv);
                            if (jn == 0) next_cycle();
                        end
                    end
                end
                if (!$feof(fd)) begin
                    $display("timeout: stimulus file did not end within %0d lines", MAX_LINES);
                    hung = 1'b1;
                end
                $fclose(fd);
                if (cur_test >= 0) end_test();
                if (!hung) random_traffic();
            end
        end
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed,
                 error_count + input_errors + dut0.u_glb_assert.assert_errors);
        if (!hung && tests_failed == 0 && error_count == 0 && input_errors == 0 &&
                dut0.u_glb_assert.assert_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== glb_input.txt ====
# test join side op bank addr data expect  (all numbers after bank in hex)
# join 1 = same cycle as next line; cfg addr = word*2 + half
1 0 host wr 0 20 1111000011110000 0
1 0 host wr 1 20 2222000022220000 0
1 0 host wr 2 20 3333000033330000 0
1 0 host wr 3 20 4444000044440000 0
1 0 host rd 0 20 0 1111000011110000
1 0 host rd 1 20 0 2222000022220000
1 0 host rd 2 20 0 3333000033330000
1 0 host rd 3 20 0 4444000044440000
2 0 host wr 1 21 aaaa5555aaaa5555 0
2 0 cgra rd 1 21 0 aaaa5555aaaa5555
2 1 cgra wr 2 22 0123456789abcdef 0
2 0 host wr 3 22 fedcba9876543210 0
2 1 host rd 2 22 0 0123456789abcdef
2 0 cgra rd 3 22 0 fedcba9876543210
2 1 host wr 0 20 5a5a5a5a5a5a5a5a 0
2 0 host rd 0 20 0 1111000011110000
2 0 cgra rd 0 20 0 5a5a5a5a5a5a5a5a
3 0 cfg wr 1 42 deadbeef 0
3 0 host rd 1 21 0 aaaa5555deadbeef
3 0 cfg wr 1 43 cafef00d 0
3 0 host rd 1 21 0 cafef00ddeadbeef
3 0 cfg rd 1 43 0 cafef00d
3 0 cfg rd 1 42 0 deadbeef
4 0 cfg rd 0 41 0 5a5a5a5a
4 0 cfg rd 1 40 0 22220000
4 0 cfg rd 2 41 0 33330000
4 0 cfg rd 3 40 0 44440000
4 0 cfg nop 0 0 0 0
4 0 cfg wr 2 40 77777777 0
4 0 cfg rd 2 40 0 77777777
5 1 host wr 2 30 1010101010101010 0
5 0 cgra wr 2 30 2020202020202020 0
5 0 cgra rd 2 30 0 1010101010101010
5 0 host wr 3 31 3131313131313131 0
5 1 cfg wr 3 62 abcdabcd 0
5 0 host wr 3 31 ffffffffffffffff 0
5 0 cgra rd 3 31 0 31313131abcdabcd

// ==== flist.f ====
+incdir+.
glb_port_pkg.sv
glb_cfg_pkg.sv
glb_bank_sram.sv
glb_cfg_adapter.sv
memory_bank.sv
global_buffer.sv
glb_assert.sv
glb_checker.sv
glb_tb.sv
